// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_exec_top \
    -Mdir obj_dir -o sim_exec_top

# The log is searched below, so a failing run must not end the script here.
./obj_dir/sim_exec_top > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run.sh: testbench reported a failure"
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    echo "run.sh: simulation ended without a result line"
    exit 1
fi
echo "run.sh: done"

// File: sim.f
+incdir+verilog
verilog/core_pkg.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/data_mem.sv
verilog/wb.sv
verilog/exec_top.sv
test/tb_clk_gen.sv
test/exec_assert.sv
test/tb_exec_top.sv

// File: test/exec_assert.sv
`timescale 1ns/1ns
`include "core_config.svh"

module exec_assert (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    input  core_pkg::load_type_e      load_type_i,
    input  core_pkg::store_type_e     store_type_i,
    input  logic [`DATA_LEN-1:0]      mem_addr_i,
    input  logic                      wb_wd_i,
    input  logic [`REG_ADDR_W-1:0]    wb_wreg_i
);

    logic is_load;
    logic is_half;
    logic is_word;

    assign is_load = (load_type_i != core_pkg::LOAD_NONE);
    assign is_half = valid_i && ((load_type_i == core_pkg::LOAD_LH_16)
                              || (load_type_i == core_pkg::LOAD_LHU_16)
                              || (store_type_i == core_pkg::STORE_SH_16));
    assign is_word = valid_i && ((load_type_i == core_pkg::LOAD_LW_32)
                              || (store_type_i == core_pkg::STORE_SW_32));

    load_dest_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wb_wd_i && is_load) |-> (wb_wreg_i != '0))
        else $error("Load writeback targets register zero.");

    half_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        is_half |-> (mem_addr_i[0] == 1'b0))
        else $error("Halfword access on an odd address.");

    word_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        is_word |-> (mem_addr_i[1:0] == 2'b00))
        else $error("Word access not aligned to four bytes.");

    idle_after_reset: assert property (@(posedge clk_i)
        (!$past(rst_n_i) && rst_n_i) |-> !wb_wd_i)
        else $error("Writeback enable high right after reset.");

endmodule

bind exec_top exec_assert u_exec_assert (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .valid_i      (valid_i),
    .load_type_i  (load_type_i),
    .store_type_i (store_type_i),
    .mem_addr_i   (mem_addr),
    .wb_wd_i      (wd_o),
    .wb_wreg_i    (wreg_o)
);

// File: test/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;                             // Released away from the sampling edge.
    end

endmodule

// File: test/tb_exec_top.sv
`timescale 1ns/1ns
`include "core_config.svh"

module tb_exec_top;

    localparam int CLK_PERIOD = 20;

    typedef struct {
        logic                      valid;
        core_pkg::alu_op_e         op;
        logic                      use_imm;
        logic [`DATA_LEN-1:0]      imm;
        logic [`REG_ADDR_W-1:0]    rs1;
        logic [`REG_ADDR_W-1:0]    rs2;
        logic [`REG_ADDR_W-1:0]    rd;
        logic                      wd;
        core_pkg::load_type_e      ld;
        core_pkg::store_type_e     st;
        logic                      exp_wd;
        logic [`REG_ADDR_W-1:0]    exp_wreg;
        logic [`DATA_LEN-1:0]      exp_wdata;
    } row_t;

    logic                   clk;
    logic                   rst_n;
    logic                   valid;
    core_pkg::alu_op_e      alu_op;
    logic                   use_imm;
    logic [`DATA_LEN-1:0]   imm;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   wd;
    core_pkg::load_type_e   load_type;
    core_pkg::store_type_e  store_type;
    logic                   wd_o;
    logic [`REG_ADDR_W-1:0] wreg_o;
    logic [`DATA_LEN-1:0]   wdata_o;

    row_t                   rows [$];
    logic [`DATA_LEN-1:0]   reg_model [0:`REG_NUM-1];
    logic [7:0]             mem_model [0:4*`MEM_WORDS-1];    // Byte-addressed, little endian.
    logic [31:0]            rng_state;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    exec_top u_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .valid_i      (valid),
        .alu_op_i     (alu_op),
        .use_imm_i    (use_imm),
        .imm_i        (imm),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .rd_i         (rd),
        .wd_i         (wd),
        .load_type_i  (load_type),
        .store_type_i (store_type),
        .wd_o         (wd_o),
        .wreg_o       (wreg_o),
        .wdata_o      (wdata_o)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model.

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] alu_ref(core_pkg::alu_op_e op, logic [31:0] a,
                                            logic [31:0] b);
        case (op)
            core_pkg::ALU_ADD: return a + b;
            core_pkg::ALU_SUB: return a - b;
            core_pkg::ALU_AND: return a & b;
            core_pkg::ALU_OR:  return a | b;
            core_pkg::ALU_XOR: return a ^ b;
            core_pkg::ALU_SLL: return a << b[4:0];
            core_pkg::ALU_SRL: return a >> b[4:0];
            core_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:           return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] load_ref(core_pkg::load_type_e ld, logic [31:0] addr);
        logic [9:0]  a;
        logic [31:0] w;
        a = addr[9:0];
        w = {mem_model[a + 10'd3], mem_model[a + 10'd2], mem_model[a + 10'd1], mem_model[a]};
        case (ld)
            core_pkg::LOAD_LB_8:   return {{24{w[7]}}, w[7:0]};
            core_pkg::LOAD_LBU_8:  return {24'd0, w[7:0]};
            core_pkg::LOAD_LH_16:  return {{16{w[15]}}, w[15:0]};
            core_pkg::LOAD_LHU_16: return {16'd0, w[15:0]};
            default:               return w;
        endcase
    endfunction

    // Appends one micro-op and advances the model as the DUT should.
    function automatic void add_row(logic v, core_pkg::alu_op_e op, logic ui, logic [31:0] iv,
                                    logic [4:0] s1, logic [4:0] s2, logic [4:0] d, logic w,
                                    core_pkg::load_type_e ld, core_pkg::store_type_e st);
        row_t        r;
        logic [31:0] sd;
        logic [31:0] res;
        logic [9:0]  ma;
        sd  = reg_model[s2];
        res = alu_ref(op, reg_model[s1], ui ? iv : sd);
        r.valid     = v;
        r.op        = op;
        r.use_imm   = ui;
        r.imm       = iv;
        r.rs1       = s1;
        r.rs2       = s2;
        r.rd        = d;
        r.wd        = w;
        r.ld        = ld;
        r.st        = st;
        r.exp_wd    = v && w;
        r.exp_wreg  = d;
        r.exp_wdata = (ld != core_pkg::LOAD_NONE) ? load_ref(ld, res) : res;
        if (v && st != core_pkg::STORE_NONE) begin
            ma = res[9:0];
            mem_model[ma] = sd[7:0];
            if (st != core_pkg::STORE_SB_8) begin
                mem_model[ma + 10'd1] = sd[15:8];
            end
            if (st == core_pkg::STORE_SW_32) begin
                mem_model[ma + 10'd2] = sd[23:16];
                mem_model[ma + 10'd3] = sd[31:24];
            end
        end
        if (r.exp_wd && d != 5'd0) begin
            reg_model[d] = r.exp_wdata;
        end
        rows.push_back(r);
    endfunction

    function automatic void set_reg(logic [4:0] d, logic [31:0] value);
        add_row(1'b1, core_pkg::ALU_ADD, 1'b1, value, 5'd0, 5'd0, d, 1'b1,
                core_pkg::LOAD_NONE, core_pkg::STORE_NONE);
    endfunction

    function automatic void read_reg(logic [4:0] s);
        add_row(1'b1, core_pkg::ALU_OR, 1'b0, 32'd0, s, 5'd0, 5'd0, 1'b0,
                core_pkg::LOAD_NONE, core_pkg::STORE_NONE);
    endfunction

    function automatic void store_to(logic v, core_pkg::store_type_e st, logic [4:0] base,
                                     logic [31:0] off, logic [4:0] src);
        add_row(v, core_pkg::ALU_ADD, 1'b1, off, base, src, 5'd0, 1'b0,
                core_pkg::LOAD_NONE, st);
    endfunction

    function automatic void load_from(core_pkg::load_type_e ld, logic [4:0] d,
                                      logic [4:0] base, logic [31:0] off);
        add_row(1'b1, core_pkg::ALU_ADD, 1'b1, off, base, 5'd0, d, 1'b1, ld,
                core_pkg::STORE_NONE);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus table.

    function automatic void build_table();
        logic [31:0] base;
        for (int r = 0; r < `REG_NUM; r++) begin
            read_reg(5'(r));
        end
        set_reg(5'd0, next_rand());                 // Must not stick.
        read_reg(5'd0);
        for (int n = 0; n < 4; n++) begin
            set_reg(5'd1, next_rand());
            set_reg(5'd2, next_rand());
            for (int k = 0; k < 8; k++) begin
                add_row(1'b1, core_pkg::alu_op_e'(3'(k)), 1'b0, 32'd0, 5'd1, 5'd2, 5'd3, 1'b1,
                        core_pkg::LOAD_NONE, core_pkg::STORE_NONE);
                add_row(1'b1, core_pkg::alu_op_e'(3'(k)), 1'b1, next_rand(), 5'd1, 5'd0, 5'd4,
                        1'b1, core_pkg::LOAD_NONE, core_pkg::STORE_NONE);
            end
        end
        for (int n = 0; n < 8; n++) begin
            base = next_rand() & 32'h0000_03f0;
            set_reg(5'd5, base);
            set_reg(5'd6, next_rand());
            base = next_rand() & 32'h0000_000c;     // Aligned offset on top of the base.
            store_to(1'b1, core_pkg::STORE_SW_32, 5'd5, base, 5'd6);
            load_from(core_pkg::LOAD_LW_32, 5'd7, 5'd5, base);
        end
        set_reg(5'd5, 32'h0000_0100);
        for (int off = 0; off < 4; off++) begin
            set_reg(5'd6, next_rand());
            store_to(1'b1, core_pkg::STORE_SW_32, 5'd5, 32'd0, 5'd6);
            set_reg(5'd8, next_rand());
            store_to(1'b1, core_pkg::STORE_SB_8, 5'd5, off, 5'd8);
            load_from(core_pkg::LOAD_LW_32, 5'd9, 5'd5, 32'd0);
            if (off % 2 == 0) begin
                set_reg(5'd8, next_rand());
                store_to(1'b1, core_pkg::STORE_SH_16, 5'd5, off, 5'd8);
                load_from(core_pkg::LOAD_LW_32, 5'd9, 5'd5, 32'd0);
            end
        end
        set_reg(5'd5, 32'h0000_0200);
        set_reg(5'd6, 32'h7f80_807f);               // Bytes and halves with MSB set and clear.
        store_to(1'b1, core_pkg::STORE_SW_32, 5'd5, 32'd0, 5'd6);
        set_reg(5'd6, 32'h807f_7f80);
        store_to(1'b1, core_pkg::STORE_SW_32, 5'd5, 32'd4, 5'd6);
        for (int off = 0; off < 8; off++) begin
            load_from(core_pkg::LOAD_LB_8, 5'd11, 5'd5, off);
            load_from(core_pkg::LOAD_LBU_8, 5'd12, 5'd5, off);
            if (off % 2 == 0) begin
                load_from(core_pkg::LOAD_LH_16, 5'd13, 5'd5, off);
                load_from(core_pkg::LOAD_LHU_16, 5'd14, 5'd5, off);
            end
        end
        add_row(1'b0, core_pkg::ALU_ADD, 1'b1, next_rand(), 5'd0, 5'd0, 5'd10, 1'b1,
                core_pkg::LOAD_NONE, core_pkg::STORE_NONE);
        read_reg(5'd10);
        set_reg(5'd6, next_rand());
        store_to(1'b0, core_pkg::STORE_SW_32, 5'd5, 32'd0, 5'd6);
        load_from(core_pkg::LOAD_LW_32, 5'd9, 5'd5, 32'd0);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Driving and checking.

    task automatic stop_on_timeout(string what);
        $display("Timeout while waiting for %s.", what);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic wait_clk_fall();
        int steps;
        steps = 0;
        while (clk !== 1'b1) begin
            #1;
            steps++;
            if (steps > CLK_PERIOD) stop_on_timeout("the clock to rise");
        end
        while (clk !== 1'b0) begin
            #1;
            steps++;
            if (steps > 2 * CLK_PERIOD) stop_on_timeout("the clock to fall");
        end
    endtask

    task automatic check_value(string name, int row, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] row %0d %s: got 0x%08h, expected 0x%08h", row, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic apply_row(int i);
        wait_clk_fall();
        valid      = rows[i].valid;
        alu_op     = rows[i].op;
        use_imm    = rows[i].use_imm;
        imm        = rows[i].imm;
        rs1        = rows[i].rs1;
        rs2        = rows[i].rs2;
        rd         = rows[i].rd;
        wd         = rows[i].wd;
        load_type  = rows[i].ld;
        store_type = rows[i].st;
        #(CLK_PERIOD / 2 - 3);                      // Just ahead of the next rising edge.
        check_value("wd_o", i, 32'(wd_o), 32'(rows[i].exp_wd));
        check_value("wreg_o", i, 32'(wreg_o), 32'(rows[i].exp_wreg));
        check_value("wdata_o", i, wdata_o, rows[i].exp_wdata);
    endtask

    initial begin
        int waited;
        valid      = 1'b0;
        alu_op     = core_pkg::ALU_ADD;
        use_imm    = 1'b0;
        imm        = '0;
        rs1        = '0;
        rs2        = '0;
        rd         = '0;
        wd         = 1'b0;
        load_type  = core_pkg::LOAD_NONE;
        store_type = core_pkg::STORE_NONE;
        rng_state  = 32'd67536;
        for (int r = 0; r < `REG_NUM; r++) begin
            reg_model[r] = '0;
        end
        build_table();
        waited = 0;
        while (rst_n !== 1'b1) begin
            wait_clk_fall();
            waited++;
            if (waited > 20) stop_on_timeout("reset release");
        end
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end
        wait_clk_fall();
        valid = 1'b0;
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ns
`include "core_config.svh"

module alu (
    input  core_pkg::alu_op_e         op_i,
    input  logic [`DATA_LEN-1:0]      a_i,
    input  logic [`DATA_LEN-1:0]      b_i,
    output logic [`DATA_LEN-1:0]      result_o
);

    localparam int SHAMT_W = $clog2(`DATA_LEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;

    assign shamt     = b_i[SHAMT_W-1:0];            // Only the low bits count.
    assign lt_signed = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            core_pkg::ALU_ADD: begin
                result_o = a_i + b_i;               // Also forms load and store addresses.
            end
            core_pkg::ALU_SUB: begin
                result_o = a_i - b_i;
            end
            core_pkg::ALU_AND: begin
                result_o = a_i & b_i;
            end
            core_pkg::ALU_OR: begin
                result_o = a_i | b_i;
            end
            core_pkg::ALU_XOR: begin
                result_o = a_i ^ b_i;
            end
            core_pkg::ALU_SLL: begin
                result_o = a_i << shamt;
            end
            core_pkg::ALU_SRL: begin
                result_o = a_i >> shamt;
            end
            core_pkg::ALU_SLT: begin
                result_o = {{(`DATA_LEN-1){1'b0}}, lt_signed};
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// File: verilog/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath and register file.

`define DATA_LEN    32          // Data and byte address width.
`define REG_ADDR_W  5           // Register index width.
`define REG_NUM     32          // Architectural registers including x0.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data memory.

`define MEM_WORDS   256         // Depth in 32-bit words.
`define MEM_MASK_W  8           // Byte-enable width with one bit per byte lane.

// Byte-enable patterns before alignment to the byte offset.
`define MEM_MASK_8  8'h01
`define MEM_MASK_16 8'h03
`define MEM_MASK_32 8'h0f

`endif

// File: verilog/core_pkg.sv
package core_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU operations.

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7                      // Signed compare.
    } alu_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory access types.

    typedef enum logic [2:0] {
        LOAD_NONE   = 3'd0,                 // Any other value selects load data.
        LOAD_LB_8   = 3'd1,
        LOAD_LH_16  = 3'd2,
        LOAD_LW_32  = 3'd3,
        LOAD_LBU_8  = 3'd4,
        LOAD_LHU_16 = 3'd5
    } load_type_e;

    typedef enum logic [1:0] {
        STORE_NONE  = 2'd0,
        STORE_SB_8  = 2'd1,
        STORE_SH_16 = 2'd2,
        STORE_SW_32 = 2'd3
    } store_type_e;

endpackage

// File: verilog/data_mem.sv
`timescale 1ns/1ns
`include "core_config.svh"

module data_mem (
    input  logic                      clk_i,
    input  logic [`DATA_LEN-1:0]      addr_i,
    input  logic [`MEM_MASK_W-1:0]    rmask_i,
    output logic [`DATA_LEN-1:0]      rdata_o,
    input  logic                      we_i,
    input  logic [`MEM_MASK_W-1:0]    wmask_i,
    input  logic [`DATA_LEN-1:0]      wdata_i
);

    localparam int NUM_BYTES = `DATA_LEN / 8;
    localparam int OFF_W     = $clog2(NUM_BYTES);
    localparam int IDX_W     = $clog2(`MEM_WORDS);

    logic [`DATA_LEN-1:0]   mem [0:`MEM_WORDS-1];
    logic [IDX_W-1:0]       word_idx;
    logic [OFF_W-1:0]       byte_off;
    logic [`DATA_LEN-1:0]   rword_sh;
    logic [`DATA_LEN-1:0]   rbyte_mask;
    logic [`MEM_MASK_W-1:0] wmask_sh;
    logic [`DATA_LEN-1:0]   wdata_sh;

    assign byte_off = addr_i[OFF_W-1:0];
    assign word_idx = addr_i[OFF_W +: IDX_W];           // Upper address bits wrap.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read side.

    assign rword_sh = mem[word_idx] >> {byte_off, 3'b000};

    always_comb begin
        for (int b = 0; b < NUM_BYTES; b++) begin
            rbyte_mask[8*b +: 8] = {8{rmask_i[b]}};
        end
    end

    assign rdata_o = rword_sh & rbyte_mask;             // Bytes past the access width read 0.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write side.

    assign wmask_sh = wmask_i << byte_off;
    assign wdata_sh = wdata_i << {byte_off, 3'b000};

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (wmask_sh[b]) begin
                    mem[word_idx][8*b +: 8] <= wdata_sh[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: verilog/exec_top.sv
`timescale 1ns/1ns
`include "core_config.svh"

module exec_top (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    input  core_pkg::alu_op_e         alu_op_i,
    input  logic                      use_imm_i,
    input  logic [`DATA_LEN-1:0]      imm_i,
    input  logic [`REG_ADDR_W-1:0]    rs1_i,
    input  logic [`REG_ADDR_W-1:0]    rs2_i,
    input  logic [`REG_ADDR_W-1:0]    rd_i,
    input  logic                      wd_i,
    input  core_pkg::load_type_e      load_type_i,
    input  core_pkg::store_type_e     store_type_i,
    output logic                      wd_o,
    output logic [`REG_ADDR_W-1:0]    wreg_o,
    output logic [`DATA_LEN-1:0]      wdata_o
);

    logic [`DATA_LEN-1:0]   rs1_data;
    logic [`DATA_LEN-1:0]   rs2_data;
    logic [`DATA_LEN-1:0]   alu_b;
    logic [`DATA_LEN-1:0]   alu_result;
    logic                   wd_q;
    logic                   store_en;
    logic [`DATA_LEN-1:0]   mem_addr;
    logic [`MEM_MASK_W-1:0] mem_rmask;
    logic [`DATA_LEN-1:0]   mem_rdata;
    logic                   mem_wen;
    logic [`MEM_MASK_W-1:0] mem_wmask;
    logic [`DATA_LEN-1:0]   mem_wdata;

    // The only place where valid_i qualifies state changes.
    assign wd_q     = valid_i && wd_i;
    assign store_en = valid_i && (store_type_i != core_pkg::STORE_NONE);
    assign alu_b    = use_imm_i ? imm_i : rs2_data;

    reg_file u_reg_file (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .raddr1_i (rs1_i),
        .raddr2_i (rs2_i),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .we_i     (wd_o),                   // Writeback bus loops back here.
        .waddr_i  (wreg_o),
        .wdata_i  (wdata_o)
    );

    alu u_alu (
        .op_i     (alu_op_i),
        .a_i      (rs1_data),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    data_mem u_data_mem (
        .clk_i    (clk_i),
        .addr_i   (mem_addr),
        .rmask_i  (mem_rmask),
        .rdata_o  (mem_rdata),
        .we_i     (mem_wen),
        .wmask_i  (mem_wmask),
        .wdata_i  (mem_wdata)
    );

    wb u_wb (
        .wd_i         (wd_q),
        .wreg_i       (rd_i),
        .alu_result_i (alu_result),
        .mem_wen_i    (store_en),
        .mem_wdata_i  (rs2_data),
        .load_type_i  (load_type_i),
        .store_type_i (store_type_i),
        .mem_rdata_i  (mem_rdata),
        .mem_addr_o   (mem_addr),
        .mem_rmask_o  (mem_rmask),
        .mem_wen_o    (mem_wen),
        .mem_wmask_o  (mem_wmask),
        .mem_wdata_o  (mem_wdata),
        .wd_o         (wd_o),
        .wreg_o       (wreg_o),
        .wdata_o      (wdata_o)
    );

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ns
`include "core_config.svh"

module reg_file (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [`REG_ADDR_W-1:0]    raddr1_i,
    input  logic [`REG_ADDR_W-1:0]    raddr2_i,
    output logic [`DATA_LEN-1:0]      rdata1_o,
    output logic [`DATA_LEN-1:0]      rdata2_o,
    input  logic                      we_i,
    input  logic [`REG_ADDR_W-1:0]    waddr_i,
    input  logic [`DATA_LEN-1:0]      wdata_i
);

    logic [`DATA_LEN-1:0] regs [1:`REG_NUM-1];      // No storage behind x0.
    logic                 wr_ok;

    assign wr_ok = we_i && (waddr_i != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // There is no bypass from the write port, so a write shows up one cycle later.
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: verilog/wb.sv
`timescale 1ns/1ns
`include "core_config.svh"

module wb (
    input  logic                      wd_i,
    input  logic [`REG_ADDR_W-1:0]    wreg_i,
    input  logic [`DATA_LEN-1:0]      alu_result_i,
    input  logic                      mem_wen_i,
    input  logic [`DATA_LEN-1:0]      mem_wdata_i,
    input  core_pkg::load_type_e      load_type_i,
    input  core_pkg::store_type_e     store_type_i,
    input  logic [`DATA_LEN-1:0]      mem_rdata_i,
    output logic [`DATA_LEN-1:0]      mem_addr_o,
    output logic [`MEM_MASK_W-1:0]    mem_rmask_o,
    output logic                      mem_wen_o,
    output logic [`MEM_MASK_W-1:0]    mem_wmask_o,
    output logic [`DATA_LEN-1:0]      mem_wdata_o,
    output logic                      wd_o,
    output logic [`REG_ADDR_W-1:0]    wreg_o,
    output logic [`DATA_LEN-1:0]      wdata_o
);

    logic                 mem_to_reg;
    logic [`DATA_LEN-1:0] load_data;

    assign mem_to_reg = (load_type_i != core_pkg::LOAD_NONE);
    assign mem_addr_o = alu_result_i;                   // Same address for read and write.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Byte masks.

    always_comb begin
        case (load_type_i)
            core_pkg::LOAD_LB_8, core_pkg::LOAD_LBU_8:   mem_rmask_o = `MEM_MASK_8;
            core_pkg::LOAD_LH_16, core_pkg::LOAD_LHU_16: mem_rmask_o = `MEM_MASK_16;
            core_pkg::LOAD_LW_32:                        mem_rmask_o = `MEM_MASK_32;
            default:                                     mem_rmask_o = '0;
        endcase
    end

    always_comb begin
        case (store_type_i)
            core_pkg::STORE_SB_8:  mem_wmask_o = `MEM_MASK_8;
            core_pkg::STORE_SH_16: mem_wmask_o = `MEM_MASK_16;
            core_pkg::STORE_SW_32: mem_wmask_o = `MEM_MASK_32;
            default:               mem_wmask_o = '0;
        endcase
    end

    assign mem_wen_o   = mem_wen_i && (mem_wmask_o != '0);
    assign mem_wdata_o = mem_wdata_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load extension and writeback select.

    always_comb begin
        case (load_type_i)
            core_pkg::LOAD_LB_8:  load_data = {{(`DATA_LEN-8){mem_rdata_i[7]}}, mem_rdata_i[7:0]};
            core_pkg::LOAD_LH_16: load_data = {{(`DATA_LEN-16){mem_rdata_i[15]}},
                                               mem_rdata_i[15:0]};
            default:              load_data = mem_rdata_i;  // Upper bytes already cleared.
        endcase
    end

    assign wd_o    = wd_i;
    assign wreg_o  = wreg_i;
    assign wdata_o = mem_to_reg ? load_data : alu_result_i;

endmodule
